// File: hdl/dep_cfg.svh
`ifndef DEP_CFG_SVH
`define DEP_CFG_SVH

// general-purpose register file.
`define DEP_NUM_GPR 8

// three scoreboard bits per gpr: low byte, second byte, upper half.
`define DEP_GPR_SB_W 24

// one bit per register.
`define DEP_SEG_SB_W 8
`define DEP_MM_SB_W 8

`endif

// File: hdl/dep_pkg.sv
`include "dep_cfg.svh"

package dep_pkg;

   typedef enum logic [1:0] {
      sz8  = 2'b00,
      sz16 = 2'b01,
      sz32 = 2'b10
   } opsize_t;

   // destination class, the opcode as seen by this stage.
   typedef enum logic [1:0] {
      dst_none = 2'b00,
      dst_gpr  = 2'b01,
      dst_seg  = 2'b10,
      dst_mm   = 2'b11
   } dst_kind_t;

   typedef struct packed {
      logic       needed;
      logic [2:0] id;
      opsize_t    size;
   } src_desc_t;

   typedef enum logic {
      st_idle = 1'b0,
      st_hold = 1'b1
   } ctrl_state_t;

   localparam int GPR_BITS = `DEP_GPR_SB_W / `DEP_NUM_GPR;

   // scoreboard bits touched by a sized gpr operand.
   function automatic logic [`DEP_GPR_SB_W-1:0] gpr_mask(opsize_t size, logic [2:0] id);
      logic [2:0]               owner;
      logic [2:0]               bits;
      logic [`DEP_GPR_SB_W-1:0] m;
      owner = id;
      case (size)
         sz8: begin
            owner = {1'b0, id[1:0]};         // ids 4..7 are the second byte of 0..3.
            bits  = id[2] ? 3'b010 : 3'b001;
         end
         sz16:    bits = 3'b011;
         default: bits = 3'b111;
      endcase
      m = '0;
      m[owner*GPR_BITS +: 3] = bits;
      return m;
   endfunction

endpackage

// File: hdl/stage_sb_if.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

// destinations owned by one pipeline stage.
interface stage_sb_if;
   logic                     v;
   logic [`DEP_GPR_SB_W-1:0] gpr;
   logic [`DEP_SEG_SB_W-1:0] seg;
   logic [`DEP_MM_SB_W-1:0]  mm;

   modport producer (
      output v, gpr, seg, mm
   );

   modport consumer (
      input v, gpr, seg, mm
   );
endinterface

// File: hdl/sb_encode.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module sb_encode (
   input  dep_pkg::dst_kind_t        dst_kind,
   input  logic [2:0]                dst_id,
   input  dep_pkg::opsize_t          dst_size,
   output logic [`DEP_GPR_SB_W-1:0]  gpr_sb,
   output logic [`DEP_SEG_SB_W-1:0]  seg_sb,
   output logic [`DEP_MM_SB_W-1:0]   mm_sb
);

   always_comb begin
      gpr_sb = '0;
      seg_sb = '0;
      mm_sb  = '0;
      case (dst_kind)
         dep_pkg::dst_gpr: gpr_sb = dep_pkg::gpr_mask(dst_size, dst_id);
         dep_pkg::dst_seg: seg_sb[dst_id] = 1'b1;
         dep_pkg::dst_mm:  mm_sb[dst_id] = 1'b1;
         dep_pkg::dst_none: begin
            // no register written.
         end
      endcase
   end

endmodule

// File: hdl/gpr_scoreboard_check.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module gpr_scoreboard_check (
   input  logic                     stage_v,
   input  dep_pkg::src_desc_t       src,
   input  logic [`DEP_GPR_SB_W-1:0] gpr_sb,
   output logic                     stall
);

   logic [`DEP_GPR_SB_W-1:0] src_mask;
   logic [`DEP_GPR_SB_W-1:0] busy;

   // byte lanes this source reads, at its owning register.
   assign src_mask = dep_pkg::gpr_mask(src.size, src.id);
   assign busy     = src_mask & gpr_sb;

   assign stall = stage_v & src.needed & (|busy);

endmodule

// File: hdl/reg_dependency_check.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module reg_dependency_check (
   input  logic               stage_v,
   input  dep_pkg::src_desc_t sr1,
   input  dep_pkg::src_desc_t sr2,
   input  logic               seg1_needed,
   input  logic [2:0]         seg1_id,
   input  logic               mm1_needed,
   stage_sb_if.consumer       ag2,
   stage_sb_if.consumer       me,
   stage_sb_if.consumer       me2,
   stage_sb_if.consumer       ex,
   output logic               dep_stall
);

   logic [`DEP_GPR_SB_W-1:0] gpr_busy;
   logic [`DEP_SEG_SB_W-1:0] seg_busy;
   logic [`DEP_MM_SB_W-1:0]  mm_busy;
   logic sr1_stall, sr2_stall, seg1_stall, mm1_stall;

   // union of every valid younger stage.
   assign gpr_busy = ({`DEP_GPR_SB_W{ag2.v}} & ag2.gpr) | ({`DEP_GPR_SB_W{me.v}} & me.gpr) |
                     ({`DEP_GPR_SB_W{me2.v}} & me2.gpr) | ({`DEP_GPR_SB_W{ex.v}} & ex.gpr);
   assign seg_busy = ({`DEP_SEG_SB_W{ag2.v}} & ag2.seg) | ({`DEP_SEG_SB_W{me.v}} & me.seg) |
                     ({`DEP_SEG_SB_W{me2.v}} & me2.seg) | ({`DEP_SEG_SB_W{ex.v}} & ex.seg);
   assign mm_busy  = ({`DEP_MM_SB_W{ag2.v}} & ag2.mm) | ({`DEP_MM_SB_W{me.v}} & me.mm) |
                     ({`DEP_MM_SB_W{me2.v}} & me2.mm) | ({`DEP_MM_SB_W{ex.v}} & ex.mm);

   gpr_scoreboard_check u_gpr_check_sr1 (
      .stage_v (stage_v),
      .src     (sr1),
      .gpr_sb  (gpr_busy),
      .stall   (sr1_stall)
   );

   gpr_scoreboard_check u_gpr_check_sr2 (
      .stage_v (stage_v),
      .src     (sr2),
      .gpr_sb  (gpr_busy),
      .stall   (sr2_stall)
   );

   assign seg1_stall = stage_v & seg1_needed & seg_busy[seg1_id];
   assign mm1_stall  = stage_v & mm1_needed & mm_busy[sr1.id];  // mmx source shares sr1's id.

   assign dep_stall = sr1_stall | sr2_stall | seg1_stall | mm1_stall;

endmodule

// File: hdl/stage_pipe.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module stage_pipe (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     issue,
   input  logic [`DEP_GPR_SB_W-1:0] gpr_sb,
   input  logic [`DEP_SEG_SB_W-1:0] seg_sb,
   input  logic [`DEP_MM_SB_W-1:0]  mm_sb,
   stage_sb_if.producer             ag2,
   stage_sb_if.producer             me,
   stage_sb_if.producer             me2,
   stage_sb_if.producer             ex
);

   always_ff @(posedge clk) begin
      if (reset) begin
         ag2.v <= 1'b0;
         me.v  <= 1'b0;
         me2.v <= 1'b0;
         ex.v  <= 1'b0;
      end else begin
         ag2.v <= issue;   // bubble when nothing issues.
         me.v  <= ag2.v;
         me2.v <= me.v;
         ex.v  <= me2.v;   // retires on the next edge.
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         ag2.gpr <= gpr_sb;
         ag2.seg <= seg_sb;
         ag2.mm  <= mm_sb;
      end
      me.gpr  <= ag2.gpr;
      me.seg  <= ag2.seg;
      me.mm   <= ag2.mm;
      me2.gpr <= me.gpr;
      me2.seg <= me.seg;
      me2.mm  <= me.mm;
      ex.gpr  <= me2.gpr;
      ex.seg  <= me2.seg;
      ex.mm   <= me2.mm;
   end

endmodule

// File: hdl/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
   input  logic               clk,
   input  logic               reset,
   input  logic               in_valid,
   input  logic [3:0]         in_tag,
   input  dep_pkg::src_desc_t sr1,
   input  dep_pkg::src_desc_t sr2,
   input  logic               seg1_needed,
   input  logic [2:0]         seg1_id,
   input  logic               mm1_needed,
   input  dep_pkg::dst_kind_t dst_kind,
   input  logic [2:0]         dst_id,
   input  dep_pkg::opsize_t   dst_size,
   input  logic               dep_stall,
   output logic               ready,
   output logic               stage_v,
   output dep_pkg::src_desc_t held_sr1,
   output dep_pkg::src_desc_t held_sr2,
   output logic               held_seg1_needed,
   output logic [2:0]         held_seg1_id,
   output logic               held_mm1_needed,
   output dep_pkg::dst_kind_t held_dst_kind,
   output logic [2:0]         held_dst_id,
   output dep_pkg::opsize_t   held_dst_size,
   output logic               issue,
   output logic [3:0]         issue_tag
);

   dep_pkg::ctrl_state_t state;
   logic                 accept;

   assign stage_v = (state == dep_pkg::st_hold);
   assign issue   = stage_v & ~dep_stall;
   assign ready   = ~stage_v | issue;    // empty, or leaving this cycle.
   assign accept  = in_valid & ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dep_pkg::st_idle;
      end else if (accept) begin
         state <= dep_pkg::st_hold;
      end else if (issue) begin
         state <= dep_pkg::st_idle;
      end
   end

   // read-stage instruction.
   always_ff @(posedge clk) begin
      if (accept) begin
         held_sr1         <= sr1;
         held_sr2         <= sr2;
         held_seg1_needed <= seg1_needed;
         held_seg1_id     <= seg1_id;
         held_mm1_needed  <= mm1_needed;
         held_dst_kind    <= dst_kind;
         held_dst_id      <= dst_id;
         held_dst_size    <= dst_size;
         issue_tag        <= in_tag;
      end
   end

endmodule

// File: hdl/dep_issue_top.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module dep_issue_top (
   input  logic               clk,
   input  logic               reset,
   input  logic               in_valid,
   input  logic [3:0]         in_tag,
   input  dep_pkg::dst_kind_t dst_kind,
   input  logic [2:0]         dst_id,
   input  dep_pkg::opsize_t   dst_size,
   input  logic               sr1_needed,
   input  logic [2:0]         sr1_id,
   input  dep_pkg::opsize_t   sr1_size,
   input  logic               sr2_needed,
   input  logic [2:0]         sr2_id,
   input  dep_pkg::opsize_t   sr2_size,
   input  logic               seg1_needed,
   input  logic [2:0]         seg1_id,
   input  logic               mm1_needed,
   output logic               ready,
   output logic               issue_valid,
   output logic [3:0]         issue_tag,
   output logic               dep_stall
);

   dep_pkg::src_desc_t       sr1, sr2, held_sr1, held_sr2;
   dep_pkg::dst_kind_t       held_dst_kind;
   dep_pkg::opsize_t         held_dst_size;
   logic [2:0]               held_dst_id, held_seg1_id;
   logic                     held_seg1_needed, held_mm1_needed;
   logic                     stage_v, issue;
   logic [`DEP_GPR_SB_W-1:0] gpr_sb;
   logic [`DEP_SEG_SB_W-1:0] seg_sb;
   logic [`DEP_MM_SB_W-1:0]  mm_sb;

   stage_sb_if ag2_sb ();
   stage_sb_if me_sb ();
   stage_sb_if me2_sb ();
   stage_sb_if ex_sb ();

   assign sr1 = '{needed: sr1_needed, id: sr1_id, size: sr1_size};
   assign sr2 = '{needed: sr2_needed, id: sr2_id, size: sr2_size};

   assign issue_valid = issue;

   issue_ctrl u_issue_ctrl (
      .clk (clk), .reset (reset),
      .in_valid (in_valid), .in_tag (in_tag),
      .sr1 (sr1), .sr2 (sr2),
      .seg1_needed (seg1_needed), .seg1_id (seg1_id), .mm1_needed (mm1_needed),
      .dst_kind (dst_kind), .dst_id (dst_id), .dst_size (dst_size),
      .dep_stall (dep_stall),
      .ready (ready), .stage_v (stage_v),
      .held_sr1 (held_sr1), .held_sr2 (held_sr2),
      .held_seg1_needed (held_seg1_needed), .held_seg1_id (held_seg1_id),
      .held_mm1_needed (held_mm1_needed),
      .held_dst_kind (held_dst_kind), .held_dst_id (held_dst_id),
      .held_dst_size (held_dst_size),
      .issue (issue), .issue_tag (issue_tag)
   );

   reg_dependency_check u_reg_dependency_check (
      .stage_v (stage_v),
      .sr1 (held_sr1), .sr2 (held_sr2),
      .seg1_needed (held_seg1_needed), .seg1_id (held_seg1_id),
      .mm1_needed (held_mm1_needed),
      .ag2 (ag2_sb), .me (me_sb), .me2 (me2_sb), .ex (ex_sb),
      .dep_stall (dep_stall)
   );

   sb_encode u_sb_encode (
      .dst_kind (held_dst_kind), .dst_id (held_dst_id), .dst_size (held_dst_size),
      .gpr_sb (gpr_sb), .seg_sb (seg_sb), .mm_sb (mm_sb)
   );

   stage_pipe u_stage_pipe (
      .clk (clk), .reset (reset), .issue (issue),
      .gpr_sb (gpr_sb), .seg_sb (seg_sb), .mm_sb (mm_sb),
      .ag2 (ag2_sb), .me (me_sb), .me2 (me2_sb), .ex (ex_sb)
   );

endmodule

// File: bench/dep_issue_props.sv
`timescale 1ns/100ps

module dep_issue_props (
   input logic       clk,
   input logic       reset,
   input logic       in_valid,
   input logic [3:0] in_tag,
   input logic       ready,
   input logic       stage_v,
   input logic       issue,
   input logic [3:0] issue_tag,
   input logic       dep_stall
);

   // a stalled instruction never leaves the read stage.
   a_stall_holds: assert property (
      @(posedge clk) disable iff (reset)
         (stage_v && dep_stall) |=> (stage_v && $stable(issue_tag))
   ) else $error("read stage lost its instruction during a stall");

   // back-to-back issue needs a new instruction accepted in between.
   a_single_issue: assert property (
      @(posedge clk) disable iff (reset) issue |=> (!issue || $past(in_valid))
   ) else $error("issue held high without a new accepted instruction");

   // the read stage takes the accepted tag on the edge.
   a_accept_loads: assert property (
      @(posedge clk) disable iff (reset)
         (in_valid && ready) |=> (stage_v && issue_tag == $past(in_tag))
   ) else $error("accepted instruction not held in the read stage with its tag");

endmodule

bind issue_ctrl dep_issue_props u_props (
   .clk       (clk),
   .reset     (reset),
   .in_valid  (in_valid),
   .in_tag    (in_tag),
   .ready     (ready),
   .stage_v   (stage_v),
   .issue     (issue),
   .issue_tag (issue_tag),
   .dep_stall (dep_stall)
);

// File: bench/dep_issue_tb.sv
`timescale 1ns/100ps
`include "dep_cfg.svh"

module dep_issue_tb;

   logic               clk;
   logic               reset;
   logic               in_valid;
   logic [3:0]         in_tag;
   dep_pkg::dst_kind_t dst_kind;
   logic [2:0]         dst_id;
   dep_pkg::opsize_t   dst_size;
   logic               sr1_needed, sr2_needed, seg1_needed, mm1_needed;
   logic [2:0]         sr1_id, sr2_id, seg1_id;
   dep_pkg::opsize_t   sr1_size, sr2_size;
   logic               ready, issue_valid, dep_stall;
   logic [3:0]         issue_tag;

   int tr [0:63][0:14];   // one row per trace line.
   int ntr;
   int cyc;
   int limit;
   int errors;
   logic running;

   // expected issues in order of age.
   int q_tag [$];
   int q_hold [$];
   int q_issue [$];

   // destinations of the last four issued instructions with index 0 the newest.
   logic [`DEP_GPR_SB_W-1:0] hist_gpr [0:3];
   logic [`DEP_SEG_SB_W-1:0] hist_seg [0:3];
   logic [`DEP_MM_SB_W-1:0]  hist_mm [0:3];
   int                       hist_e [0:3];

   dep_issue_top uut (
      .clk (clk), .reset (reset), .in_valid (in_valid), .in_tag (in_tag),
      .dst_kind (dst_kind), .dst_id (dst_id), .dst_size (dst_size),
      .sr1_needed (sr1_needed), .sr1_id (sr1_id), .sr1_size (sr1_size),
      .sr2_needed (sr2_needed), .sr2_id (sr2_id), .sr2_size (sr2_size),
      .seg1_needed (seg1_needed), .seg1_id (seg1_id), .mm1_needed (mm1_needed),
      .ready (ready), .issue_valid (issue_valid), .issue_tag (issue_tag),
      .dep_stall (dep_stall)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      if (reset)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   // byte lanes of a sized gpr operand.
   // 8-bit ids 4..7 are the second byte of 0..3.
   function automatic logic [`DEP_GPR_SB_W-1:0] lane_mask(input int sz, input int id);
      logic [`DEP_GPR_SB_W-1:0] lanes;
      int                       reg_no;
      reg_no = id;
      lanes  = `DEP_GPR_SB_W'(7);
      if (sz == 0) begin
         reg_no = id % 4;
         lanes  = (id >= 4) ? `DEP_GPR_SB_W'(2) : `DEP_GPR_SB_W'(1);
      end else if (sz == 1) begin
         lanes = `DEP_GPR_SB_W'(3);
      end
      return lanes << (3 * reg_no);
   endfunction

   // cycle in which row r issues if it is held from cycle hold.
   function automatic int predict_issue(input int r, input int hold);
      logic [`DEP_GPR_SB_W-1:0] rd_gpr;
      logic [`DEP_SEG_SB_W-1:0] rd_seg;
      logic [`DEP_MM_SB_W-1:0]  rd_mm;
      int                       t;
      rd_gpr = '0;
      rd_seg = '0;
      rd_mm  = '0;
      if (tr[r][5] != 0) rd_gpr = rd_gpr | lane_mask(tr[r][7], tr[r][6]);
      if (tr[r][8] != 0) rd_gpr = rd_gpr | lane_mask(tr[r][10], tr[r][9]);
      if (tr[r][11] != 0) rd_seg[tr[r][12]] = 1'b1;
      if (tr[r][13] != 0) rd_mm[tr[r][6]] = 1'b1;   // mmx source uses sr1's id.
      t = hold;
      for (int k = 3; k >= 0; k--) begin
         if (hist_e[k] + 4 >= t && ((|(rd_gpr & hist_gpr[k])) ||
             (|(rd_seg & hist_seg[k])) || (|(rd_mm & hist_mm[k]))))
            t = hist_e[k] + 5;
      end
      return t;
   endfunction

   task automatic record_issue(input int r, input int e);
      for (int k = 3; k > 0; k--) begin
         hist_gpr[k] = hist_gpr[k-1];
         hist_seg[k] = hist_seg[k-1];
         hist_mm[k]  = hist_mm[k-1];
         hist_e[k]   = hist_e[k-1];
      end
      hist_gpr[0] = (tr[r][2] == 1) ? lane_mask(tr[r][4], tr[r][3]) : '0;
      hist_seg[0] = '0;
      hist_mm[0]  = '0;
      if (tr[r][2] == 2) hist_seg[0][tr[r][3]] = 1'b1;
      if (tr[r][2] == 3) hist_mm[0][tr[r][3]] = 1'b1;
      hist_e[0] = e;
   endtask

   task automatic load_trace();
      int    fd;
      int    n;
      int    v [0:14];
      string line;
      fd  = $fopen("bench/issue_trace.txt", "r");
      ntr = 0;
      if (fd == 0) begin
         $display("could not open bench/issue_trace.txt");
         errors++;
         return;
      end
      while (!$feof(fd) && ntr < 64) begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%d %h %d %d %d %d %d %d %d %d %d %d %d %d %d",
                     v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                     v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
         if (n == 15) begin   // comment lines fall through.
            for (int c = 0; c < 15; c++) tr[ntr][c] = v[c];
            ntr++;
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_row(input int r);
      in_valid    = 1'b1;
      in_tag      = 4'(tr[r][1]);
      dst_kind    = dep_pkg::dst_kind_t'(tr[r][2]);
      dst_id      = 3'(tr[r][3]);
      dst_size    = dep_pkg::opsize_t'(tr[r][4]);
      sr1_needed  = tr[r][5] != 0;
      sr1_id      = 3'(tr[r][6]);
      sr1_size    = dep_pkg::opsize_t'(tr[r][7]);
      sr2_needed  = tr[r][8] != 0;
      sr2_id      = 3'(tr[r][9]);
      sr2_size    = dep_pkg::opsize_t'(tr[r][10]);
      seg1_needed = tr[r][11] != 0;
      seg1_id     = 3'(tr[r][12]);
      mm1_needed  = tr[r][13] != 0;
   endtask

   // responses are sampled mid-cycle.
   always @(negedge clk) begin
      logic exp_issue;
      if (running) begin
         if (q_tag.size() > 0 && q_hold[0] <= cyc) begin
            exp_issue = (cyc == q_issue[0]);
            if (issue_valid !== exp_issue) begin
               $display("[ERROR] issue_valid exp %h got %h (cycle %0d)", exp_issue,
                        issue_valid, cyc);
               errors++;
            end
            if (dep_stall !== !exp_issue) begin
               $display("[ERROR] dep_stall exp %h got %h (cycle %0d)", !exp_issue,
                        dep_stall, cyc);
               errors++;
            end
            if (ready !== exp_issue) begin
               $display("[ERROR] ready exp %h got %h (cycle %0d)", exp_issue, ready, cyc);
               errors++;
            end
            if (exp_issue && issue_tag !== 4'(q_tag[0])) begin
               $display("[ERROR] issue_tag exp %h got %h", 4'(q_tag[0]), issue_tag);
               errors++;
            end
            if (cyc >= q_issue[0]) begin
               void'(q_tag.pop_front());
               void'(q_hold.pop_front());
               void'(q_issue.pop_front());
            end
         end else begin
            if (issue_valid !== 1'b0 || dep_stall !== 1'b0 || ready !== 1'b1) begin
               $display("[ERROR] idle outputs ready/issue_valid/dep_stall exp 1/0/0 got %h/%h/%h",
                        ready, issue_valid, dep_stall);
               errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (running && cyc >= limit) begin
         $display("timeout: run passed %0d cycles with %0d issues pending", limit,
                  q_tag.size());
         $display("errors: %0d", errors);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int extra;
      int hold;
      int t;
      logic got;
      clk = 1'b0;
      reset = 1'b1;
      running = 1'b0;
      errors = 0;
      cyc = 0;
      in_valid = 1'b0;
      in_tag = '0;
      dst_kind = dep_pkg::dst_none;
      dst_id = '0;
      dst_size = dep_pkg::sz8;
      sr1_needed = 1'b0;
      sr1_id = '0;
      sr1_size = dep_pkg::sz8;
      sr2_needed = 1'b0;
      sr2_id = '0;
      sr2_size = dep_pkg::sz8;
      seg1_needed = 1'b0;
      seg1_id = '0;
      mm1_needed = 1'b0;
      for (int k = 0; k < 4; k++) begin
         hist_gpr[k] = '0;
         hist_seg[k] = '0;
         hist_mm[k]  = '0;
         hist_e[k]   = -100;
      end
      void'($urandom(2812));
      load_trace();
      limit = ntr * 8 + 50;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      running = 1'b1;
      for (int r = 0; r < ntr; r++) begin
         // long gaps drain the pipe, so extra idle cycles there change nothing.
         extra = (tr[r][0] >= 12) ? int'($urandom % 3) : 0;
         repeat (tr[r][0] + extra) begin
            @(posedge clk);
            #1;
         end
         drive_row(r);
         got = 1'b0;
         while (!got) begin
            @(negedge clk);
            got = ready;
            @(posedge clk);
            #1;
         end
         hold = cyc;
         t = predict_issue(r, hold);
         if (t - hold != tr[r][14]) begin
            $display("model stall of %0d cycles disagrees with trace line %0d stall of %0d",
                     t - hold, r, tr[r][14]);
            errors++;
         end
         record_issue(r, t);
         q_tag.push_back(tr[r][1]);
         q_hold.push_back(hold);
         q_issue.push_back(t);
         in_valid = 1'b0;
      end
      while (q_tag.size() > 0) @(posedge clk);
      repeat (3) @(posedge clk);
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: bench/issue_trace.txt
# gap tag dst_kind dst_id dst_size sr1_needed sr1_id sr1_size sr2_needed sr2_id sr2_size
#   seg1_needed seg1_id mm1_needed stall  (kind 0 none 1 gpr 2 seg 3 mm, size 0 8b 1 16b 2 32b)
12 1 1 1 2 0 0 0 0 0 0 0 0 0 0
0 2 1 2 2 1 3 2 0 0 0 0 0 0 0
0 3 1 5 2 1 6 2 0 0 0 0 0 0 0
0 4 0 0 0 1 7 1 1 0 0 0 0 0 0
12 5 1 4 0 0 0 0 0 0 0 0 0 0 0
0 6 0 0 0 1 0 0 0 0 0 0 0 0 0
0 7 1 0 2 0 0 0 0 0 0 0 0 0 0
0 8 0 0 0 1 4 0 0 0 0 0 0 0 4
12 9 1 3 1 0 0 0 0 0 0 0 0 0 0
0 a 0 0 0 0 0 0 1 3 2 0 0 0 4
12 b 2 2 0 0 0 0 0 0 0 0 0 0 0
0 c 0 0 0 1 2 2 0 0 0 0 0 0 0
0 d 0 0 0 0 0 0 0 0 0 1 2 0 3
12 e 3 3 0 0 0 0 0 0 0 0 0 0 0
0 f 0 0 0 0 3 2 1 3 2 1 3 0 0
0 0 0 0 0 0 3 2 0 0 0 0 0 1 3
12 1 1 6 2 0 0 0 0 0 0 0 0 0 0
0 2 0 0 0 0 0 0 0 0 0 0 0 0 0
0 3 0 0 0 1 6 1 0 0 0 0 0 0 3
12 4 1 7 2 0 0 0 0 0 0 0 0 0 0
0 5 0 0 0 0 0 0 0 0 0 0 0 0 0
0 6 0 0 0 0 0 0 0 0 0 0 0 0 0
0 7 0 0 0 0 0 0 1 7 1 0 0 0 2
12 8 1 4 2 0 0 0 0 0 0 0 0 0 0
0 9 0 0 0 0 4 2 0 4 2 0 4 0 0
0 a 0 0 0 1 4 2 0 0 0 0 0 0 3
12 b 1 1 0 0 0 0 0 0 0 0 0 0 0
1 c 0 0 0 1 1 0 0 0 0 0 0 0 3

// File: dep_issue_top.f
+incdir+hdl
hdl/dep_pkg.sv
hdl/stage_sb_if.sv
hdl/sb_encode.sv
hdl/gpr_scoreboard_check.sv
hdl/reg_dependency_check.sv
hdl/stage_pipe.sv
hdl/issue_ctrl.sv
hdl/dep_issue_top.sv
bench/dep_issue_props.sv
bench/dep_issue_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dep_issue_tb
FILELIST  = dep_issue_top.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
